//--- hw/cp_pkg.sv
package cp_pkg;

    // stream and array geometry
    localparam int phit_size      = 32;               // one word of the write stream
    localparam int num_col        = 4;                // array columns fed by the tables
    localparam int sz_config      = 16;               // column control word
    localparam int dwidth_rfadd   = 5;                // table / register-file address
    localparam int dwidth_int     = 8;                // loop counters
    localparam int dwidth_double  = 64;               // packed itr output
    localparam int entry_sz_state = 16;               // one state-table entry

    localparam int words_per_entry = 2*num_col + 1;   // state word + ctrl/imm per column
    localparam int tab_depth       = 2**dwidth_rfadd; // 32 entries per table
    localparam int wcnt_w          = $clog2(words_per_entry);

    // sequencer FSM encoding
    localparam logic [1:0] st_idle     = 2'd0;        // waiting for the loader
    localparam logic [1:0] st_ready    = 2'd1;        // ready_stream_in high
    localparam logic [1:0] st_wait_rel = 2'd2;        // start seen, wait for it to drop
    localparam logic [1:0] st_exec     = 2'd3;        // walking the program

    // one state entry, decoded by its top bit
    // mode 0 holds a config row for count cycles, mode 1 ends or loops back
    typedef union packed {
        struct packed {
            logic                  mode;              // 0 here
            logic [6:0]            unused;
            logic [dwidth_int-1:0] count;             // cycles to hold the row
        } run;
        struct packed {
            logic                    mode;            // 1 here
            logic                    last;            // end of program
            logic [dwidth_rfadd-1:0] target;          // jump address for the loop
            logic                    unused;
            logic [dwidth_int-1:0]   reps;            // total passes through the loop body
        } br;
    } state_entry_u;

endpackage

//--- hw/cp_loader.sv
`timescale 1ns/100ps

module cp_loader (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                start_loader,            // one-cycle kick
    input  logic [cp_pkg::dwidth_rfadd-1:0]     num_entry_config_table,
    input  logic [cp_pkg::dwidth_rfadd-1:0]     num_entry_inbound,
    output logic [cp_pkg::dwidth_rfadd-1:0]     wr_add,                  // table row
    output logic [cp_pkg::words_per_entry-1:0]  wr_en,                   // one-hot table select
    output logic                                wr_en_rf,
    output logic [cp_pkg::dwidth_rfadd-1:0]     wr_add_rf,
    output logic                                done                     // pulse after last word
);
    import cp_pkg::*;

    logic                    cfg_busy;   // table words on the stream
    logic                    inb_busy;   // inbound words on the stream
    logic [dwidth_rfadd-1:0] entry_cnt;
    logic [wcnt_w-1:0]       word_cnt;   // position inside one entry
    logic [dwidth_rfadd-1:0] inb_cnt;
    logic [dwidth_rfadd-1:0] cfg_lim;    // sizes captured at start
    logic [dwidth_rfadd-1:0] inb_lim;
    logic                    last_word;
    logic                    last_entry;
    logic                    last_inb;

    assign last_word  = (word_cnt == wcnt_w'(words_per_entry - 1));
    assign last_entry = (entry_cnt == cfg_lim - 1'b1);
    assign last_inb   = (inb_cnt == inb_lim - 1'b1);

    // section sizes latched with the start pulse
    always_ff @(posedge clk) begin
        if (start_loader && !cfg_busy && !inb_busy) begin
            cfg_lim <= num_entry_config_table;
            inb_lim <= num_entry_inbound;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_busy  <= 1'b0;
            inb_busy  <= 1'b0;
            entry_cnt <= '0;
            word_cnt  <= '0;
            inb_cnt   <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start_loader && !cfg_busy && !inb_busy) begin
                entry_cnt <= '0;
                word_cnt  <= '0;
                inb_cnt   <= '0;
                // empty sections are skipped straight away
                cfg_busy  <= (num_entry_config_table != '0);
                inb_busy  <= (num_entry_config_table == '0) && (num_entry_inbound != '0);
                done      <= (num_entry_config_table == '0) && (num_entry_inbound == '0);
            end else if (cfg_busy) begin
                if (last_word) begin
                    word_cnt  <= '0;
                    entry_cnt <= entry_cnt + 1'b1;
                    if (last_entry) begin                // hand over to the inbound section
                        cfg_busy <= 1'b0;
                        inb_busy <= (inb_lim != '0);
                        done     <= (inb_lim == '0);
                    end
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else if (inb_busy) begin
                inb_cnt <= inb_cnt + 1'b1;
                if (last_inb) begin
                    inb_busy <= 1'b0;
                    done     <= 1'b1;
                end
            end
        end
    end

    // word k of an entry lands on enable bit k
    assign wr_en     = cfg_busy ? (words_per_entry'(1) << word_cnt) : '0;
    assign wr_add    = entry_cnt;
    assign wr_en_rf  = inb_busy;          // inbound words go out to the register file
    assign wr_add_rf = inb_cnt;

    // every table word selects exactly one table, word_cnt stays inside the entry
    a_wr_en_onehot : assert property (@(posedge clk) disable iff (!arst_n)
        cfg_busy |-> $onehot(wr_en));

    a_tab_rf_excl : assert property (@(posedge clk) disable iff (!arst_n)
        !((|wr_en) && wr_en_rf));

endmodule

//--- hw/cp_tables.sv
`timescale 1ns/100ps

module cp_tables (
    input  logic                                          clk,
    input  logic [cp_pkg::dwidth_rfadd-1:0]               rd_add,        // sequencer pointer
    input  logic [cp_pkg::dwidth_rfadd-1:0]               wr_add,
    input  logic [cp_pkg::words_per_entry-1:0]            wr_en,
    input  logic [cp_pkg::phit_size-1:0]                  wr_data,
    output cp_pkg::state_entry_u                          rd_data_state,
    output logic [cp_pkg::num_col*cp_pkg::sz_config-1:0]  rd_data_ctrl,  // column 0 in low bits
    output logic [cp_pkg::num_col*cp_pkg::phit_size-1:0]  rd_data_imm
);
    import cp_pkg::*;

    state_entry_u state_mem [tab_depth];  // program entries

    // state word keeps only its low half
    always_ff @(posedge clk) begin
        if (wr_en[0]) begin
            state_mem[wr_add] <= wr_data[entry_sz_state-1:0];
        end
    end

    assign rd_data_state = state_mem[rd_add];   // asynchronous read

    // one ctrl and one imm array per column
    // all share the row address, each has its own enable bit
    generate
        for (genvar c = 0; c < num_col; c++) begin : g_col
            logic [sz_config-1:0] ctrl_mem [tab_depth];
            logic [phit_size-1:0] imm_mem  [tab_depth];

            always_ff @(posedge clk) begin
                if (wr_en[2*c+1]) begin
                    ctrl_mem[wr_add] <= wr_data[sz_config-1:0];   // low half only
                end
                if (wr_en[2*c+2]) begin
                    imm_mem[wr_add] <= wr_data;                   // full word
                end
            end

            assign rd_data_ctrl[c*sz_config +: sz_config] = ctrl_mem[rd_add];
            assign rd_data_imm[c*phit_size +: phit_size]  = imm_mem[rd_add];
        end
    endgenerate

endmodule

//--- hw/cp_sequencer.sv
`timescale 1ns/100ps

module cp_sequencer (
    input  logic                            clk,
    input  logic                            arst_n,
    input  cp_pkg::state_entry_u            entry,            // row at smart_ptr
    input  logic                            start_inbound,    // loader finished
    input  logic                            start_stream_in,
    output logic [cp_pkg::dwidth_rfadd-1:0] smart_ptr,
    output logic [cp_pkg::dwidth_int-1:0]   itr_j,            // loop pass
    output logic [cp_pkg::dwidth_int-1:0]   itr_k,            // cycle inside a run entry
    output logic                            ready_stream_in,
    output logic                            running,
    output logic                            done
);
    import cp_pkg::*;

    logic [1:0] state;
    logic       in_exec;
    logic       is_branch;
    logic       run_last;     // final cycle of a run entry
    logic       loop_again;   // branch takes the jump

    assign in_exec   = (state == st_exec);
    assign is_branch = entry.run.mode;   // same bit in both views

    // count 0 still spends one cycle on the entry
    assign run_last = (entry.run.count == '0) || (itr_k == entry.run.count - 1'b1);

    // widened so itr_j = 255 cannot wrap
    assign loop_again = (({1'b0, itr_j} + 1'b1) < {1'b0, entry.br.reps});

    // start exchange levels
    assign ready_stream_in = (state == st_ready);

    assign running = in_exec && !is_branch && (entry.run.count != '0);
    assign done    = in_exec && is_branch && entry.br.last;   // leaves exec next edge

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            smart_ptr <= '0;
            itr_j     <= '0;
            itr_k     <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_inbound) begin
                        state <= st_ready;
                    end
                end
                st_ready: begin
                    if (start_stream_in) begin       // environment answered
                        state <= st_wait_rel;
                    end
                end
                st_wait_rel: begin
                    if (!start_stream_in) begin      // released, program starts at row 0
                        state     <= st_exec;
                        smart_ptr <= '0;
                        itr_j     <= '0;
                        itr_k     <= '0;
                    end
                end
                st_exec: begin
                    if (!is_branch) begin
                        if (run_last) begin
                            itr_k     <= '0;
                            smart_ptr <= smart_ptr + 1'b1;
                        end else begin
                            itr_k <= itr_k + 1'b1;
                        end
                    end else if (entry.br.last) begin
                        state     <= st_idle;      // back for the next load
                        smart_ptr <= '0;
                        itr_j     <= '0;
                    end else if (loop_again) begin
                        itr_j     <= itr_j + 1'b1;
                        smart_ptr <= entry.br.target;
                    end else begin
                        // loop finished, fall through
                        itr_j     <= '0;
                        smart_ptr <= smart_ptr + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // a running row never holds past its count
    a_itr_k_in_range : assert property (@(posedge clk) disable iff (!arst_n)
        running |-> (itr_k < entry.run.count));

    // every row reached in exec was written by the loader
    a_entry_known : assert property (@(posedge clk) disable iff (!arst_n)
        in_exec |-> !$isunknown(entry));

endmodule

//--- hw/control_plane.sv
`timescale 1ns/100ps

module control_plane (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic [cp_pkg::phit_size-1:0]                  wr_data,       // shared write stream
    input  logic                                          start_loader,
    input  logic                                          start_stream_in,
    input  logic [cp_pkg::dwidth_rfadd-1:0]               num_entry_config_table,
    input  logic [cp_pkg::dwidth_rfadd-1:0]               num_entry_inbound,
    output logic [cp_pkg::num_col*cp_pkg::sz_config-1:0]  rd_data_ctrl,  // to the columns
    output logic [cp_pkg::num_col*cp_pkg::phit_size-1:0]  rd_data_imm,
    output cp_pkg::state_entry_u                          rd_data_state,
    output logic [cp_pkg::dwidth_double-1:0]              itr,
    output logic                                          ready_stream_in,
    output logic                                          running,
    output logic                                          done,
    output logic                                          wr_en_rf,      // to the register file
    output logic [cp_pkg::dwidth_rfadd-1:0]               wr_add_rf
);
    import cp_pkg::*;

    logic [dwidth_rfadd-1:0]    smart_ptr;    // read row of every table
    logic [dwidth_int-1:0]      itr_j;
    logic [dwidth_int-1:0]      itr_k;
    logic [words_per_entry-1:0] wr_en;
    logic [dwidth_rfadd-1:0]    wr_add;
    logic                       done_loader;

    cp_loader u_loader (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .start_loader           (start_loader),
        .num_entry_config_table (num_entry_config_table),
        .num_entry_inbound      (num_entry_inbound),
        .wr_add                 (wr_add),
        .wr_en                  (wr_en),
        .wr_en_rf               (wr_en_rf),
        .wr_add_rf              (wr_add_rf),
        .done                   (done_loader)
    );

    cp_tables u_tables (
        .clk           (clk),
        .rd_add        (smart_ptr),
        .wr_add        (wr_add),
        .wr_en         (wr_en),
        .wr_data       (wr_data),    // no staging, written in the cycle it arrives
        .rd_data_state (rd_data_state),
        .rd_data_ctrl  (rd_data_ctrl),
        .rd_data_imm   (rd_data_imm)
    );

    cp_sequencer u_sequencer (
        .clk             (clk),
        .arst_n          (arst_n),
        .entry           (rd_data_state),
        .start_inbound   (done_loader),
        .start_stream_in (start_stream_in),
        .smart_ptr       (smart_ptr),
        .itr_j           (itr_j),
        .itr_k           (itr_k),
        .ready_stream_in (ready_stream_in),
        .running         (running),
        .done            (done)
    );

    // itr_j in 15:8, itr_k in 7:0, upper bits zero
    assign itr = {{(dwidth_double - 2*dwidth_int){1'b0}}, itr_j, itr_k};

endmodule

//--- verification/control_plane_tb.sv
`timescale 1ns/100ps

module control_plane_tb;
    import cp_pkg::*;

    localparam int max_cycles = 4000;   // well above the summed length of all tests

    logic                         clk;
    logic                         arst_n;
    logic [phit_size-1:0]         wr_data;
    logic                         start_loader;
    logic                         start_stream_in;
    logic [dwidth_rfadd-1:0]      num_entry_config_table;
    logic [dwidth_rfadd-1:0]      num_entry_inbound;
    logic [num_col*sz_config-1:0] rd_data_ctrl;
    logic [num_col*phit_size-1:0] rd_data_imm;
    state_entry_u                 rd_data_state;
    logic [dwidth_double-1:0]     itr;
    logic                         ready_stream_in;
    logic                         running;
    logic                         done;
    logic                         wr_en_rf;
    logic [dwidth_rfadd-1:0]      wr_add_rf;

    integer seed = 32'h66fb_1610;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     err_start = 0;   // errors before the current test
    int     cycles = 0;

    // program model, one row per entry
    state_entry_u                 prog_state[$];
    logic [num_col*sz_config-1:0] prog_ctrl[$];
    logic [num_col*phit_size-1:0] prog_imm[$];
    logic [phit_size-1:0]         prog_inb[$];   // words for the register file

    control_plane DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog
    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, DUT never finished the tests", cycles);
        $display("sim failed");
        $finish;
    end

    task automatic tally(input string name, input bit ok, input string got, input string exp);
        checks++;
        if (!ok) begin
            errors++;
            $display("ERR %0t %s got %s exp %s", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        tally(name, got === exp, $sformatf("%b", got), $sformatf("%b", exp));
    endtask
    task automatic check_add(input string name, input logic [dwidth_rfadd-1:0] got, exp);
        tally(name, got === exp, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask
    task automatic check_ctrl(input string name, input logic [num_col*sz_config-1:0] got, exp);
        tally(name, got === exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic check_imm(input string name, input logic [num_col*phit_size-1:0] got, exp);
        tally(name, got === exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic check_entry(input string name, input state_entry_u got, exp);
        tally(name, got === exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic check_itr(input string name, input logic [dwidth_double-1:0] got, exp);
        tally(name, got === exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    task automatic new_program();
        prog_state.delete();
        prog_ctrl.delete();
        prog_imm.delete();
        prog_inb.delete();
        err_start = errors;
    endtask

    // random ctrl and imm words for every column of the row
    task automatic push_entry(input state_entry_u e);
        logic [num_col*sz_config-1:0] c;
        logic [num_col*phit_size-1:0] m;
        logic [31:0]                  r;
        for (int i = 0; i < num_col; i++) begin
            r = next_rand();
            c[i*sz_config +: sz_config] = r[15:0];
            m[i*phit_size +: phit_size] = next_rand();
        end
        prog_state.push_back(e);
        prog_ctrl.push_back(c);
        prog_imm.push_back(m);
    endtask

    task automatic add_run(input logic [dwidth_int-1:0] count);
        state_entry_u e;
        e = '0;
        e.run.count = count;
        push_entry(e);
    endtask

    task automatic add_branch(input logic last, input logic [dwidth_rfadd-1:0] target,
                              input logic [dwidth_int-1:0] reps);
        state_entry_u e;
        e = '0;
        e.br.mode   = 1'b1;
        e.br.last   = last;
        e.br.target = target;
        e.br.reps   = reps;
        push_entry(e);
    endtask

    // streams the model, checks the rf strobes and the rise of ready
    task automatic load_program();
        logic [phit_size-1:0] words[$];
        logic [31:0]          r;
        int                   n_cfg;
        int                   pulses;
        pulses = 0;
        n_cfg  = prog_state.size() * words_per_entry;
        foreach (prog_state[e]) begin
            r = next_rand();
            words.push_back({r[31:16], prog_state[e]});   // upper half is dropped by the table
            for (int c = 0; c < num_col; c++) begin
                r = next_rand();
                words.push_back({r[31:16], prog_ctrl[e][c*sz_config +: sz_config]});
                words.push_back(prog_imm[e][c*phit_size +: phit_size]);
            end
        end
        foreach (prog_inb[i]) words.push_back(prog_inb[i]);
        start_loader           <= 1'b1;
        num_entry_config_table <= dwidth_rfadd'(prog_state.size());
        num_entry_inbound      <= dwidth_rfadd'(prog_inb.size());
        @(posedge clk);
        start_loader <= 1'b0;
        foreach (words[i]) begin
            wr_data <= words[i];
            @(negedge clk);
            check_bit("wr_en_rf", wr_en_rf, i >= n_cfg);
            if (wr_en_rf) pulses++;
            if (i >= n_cfg) check_add("wr_add_rf", wr_add_rf, dwidth_rfadd'(i - n_cfg));
            @(posedge clk);
        end
        wr_data <= next_rand();                            // idle word, never consumed
        @(negedge clk);
        check_bit("wr_en_rf", wr_en_rf, 1'b0);
        check_bit("ready_stream_in", ready_stream_in, 1'b0);   // loader done cycle
        @(posedge clk);
        @(negedge clk);
        check_bit("ready_stream_in", ready_stream_in, 1'b1);
        tally("wr_en_rf pulses", pulses == prog_inb.size(), $sformatf("%0d", pulses),
              $sformatf("%0d", prog_inb.size()));
        @(posedge clk);
    endtask

    // start exchange, then predicts every exec cycle from the model
    task automatic run_program(input int exp_run);
        state_entry_u          e;
        int                    ptr;
        int                    n_run;
        logic [dwidth_int-1:0] j;
        logic [dwidth_int-1:0] k;
        logic                  fin;
        logic                  exp_running;
        ptr   = 0;
        n_run = 0;
        j     = '0;
        k     = '0;
        fin   = 1'b0;
        start_stream_in <= 1'b1;
        @(negedge clk);
        check_bit("ready_stream_in", ready_stream_in, 1'b1);   // not sampled yet
        @(posedge clk);
        start_stream_in <= 1'b0;
        @(negedge clk);
        check_bit("ready_stream_in", ready_stream_in, 1'b0);
        while (!fin) begin
            @(posedge clk);
            @(negedge clk);
            e           = prog_state[ptr];
            exp_running = !e.run.mode && (e.run.count != '0);
            check_bit("running", running, exp_running);
            check_bit("done", done, e.br.mode && e.br.last);
            if (running) n_run++;                            // cycles the DUT drove a row
            if (exp_running) begin
                check_entry("rd_data_state", rd_data_state, e);
                check_ctrl("rd_data_ctrl", rd_data_ctrl, prog_ctrl[ptr]);
                check_imm("rd_data_imm", rd_data_imm, prog_imm[ptr]);
                check_itr("itr", itr, (dwidth_double'(j) << 8) | dwidth_double'(k));
            end
            if (!e.run.mode) begin
                if (e.run.count == '0 || int'(k) == int'(e.run.count) - 1) begin
                    k = '0;
                    ptr++;
                end else begin
                    k = k + 8'd1;                            // next cycle of the same row
                end
            end else if (e.br.last) begin
                fin = 1'b1;
            end else if (int'(j) + 1 < int'(e.br.reps)) begin
                j   = j + 8'd1;
                ptr = int'(e.br.target);                     // another pass through the body
            end else begin
                j = '0;
                ptr++;
            end
        end
        @(posedge clk);
        @(negedge clk);
        check_bit("done", done, 1'b0);                       // single pulse only
        check_bit("running", running, 1'b0);
        tally("running cycles", n_run == exp_run, $sformatf("%0d", n_run),
              $sformatf("%0d", exp_run));
        @(posedge clk);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-16s %s", name, (errors == err_start) ? "ok" : "FAILED");
    endtask

    task automatic test_reset();
        err_start = errors;
        @(negedge clk);
        check_bit("ready_stream_in", ready_stream_in, 1'b0);
        check_bit("running", running, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("wr_en_rf", wr_en_rf, 1'b0);
        @(posedge clk);
        end_test("reset");
    endtask

    task automatic test_load_inbound();
        new_program();
        add_run(8'd2);
        add_run(8'd1);
        add_branch(1'b1, 5'd0, 8'd0);
        repeat (5) prog_inb.push_back(next_rand());
        load_program();
        run_program(3);
        end_test("load and inbound");
    endtask

    task automatic test_straight();
        new_program();
        add_run(8'd2);
        add_run(8'd3);
        add_run(8'd1);
        add_branch(1'b1, 5'd0, 8'd0);
        load_program();
        run_program(6);
        end_test("straight");
    endtask

    task automatic test_loop();
        new_program();
        add_run(8'd2);
        add_run(8'd1);
        add_branch(1'b0, 5'd0, 8'd3);                        // body runs three times
        add_branch(1'b1, 5'd0, 8'd0);
        repeat (2) prog_inb.push_back(next_rand());
        load_program();
        run_program(9);
        end_test("loop");
    endtask

    task automatic test_random();
        logic [31:0] r;
        int          total;
        total = 0;
        new_program();
        for (int i = 0; i < 6; i++) begin
            r = next_rand();
            add_run(r[7:0] % 8'd5);                          // zero counts included
            total += int'(r[7:0] % 8'd5);
        end
        add_branch(1'b1, 5'd0, 8'd0);
        r = next_rand();
        repeat (int'(r[1:0])) prog_inb.push_back(next_rand());
        load_program();
        run_program(total);
        end_test("random");
    endtask

    task automatic test_reload();
        new_program();
        add_run(8'd0);
        add_run(8'd4);
        add_branch(1'b0, 5'd1, 8'd2);                        // loops back past the empty row
        add_run(8'd1);
        add_branch(1'b1, 5'd0, 8'd0);
        repeat (3) prog_inb.push_back(next_rand());
        load_program();
        run_program(9);
        end_test("reload");
    endtask

    initial begin
        arst_n                 = 1'b0;
        wr_data                = '0;
        start_loader           = 1'b0;
        start_stream_in        = 1'b0;
        num_entry_config_table = '0;
        num_entry_inbound      = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_load_inbound();
        test_straight();
        test_loop();
        test_random();
        test_reload();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/cp_pkg.sv
hw/cp_loader.sv
hw/cp_tables.sv
hw/cp_sequencer.sv
hw/control_plane.sv
verification/control_plane_tb.sv

//--- Makefile
# Verilator flow, file list in sim.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module control_plane_tb

sim:
	verilator --binary --timing --assert -f sim.f --top-module control_plane_tb -o cp_sim
	./obj_dir/cp_sim | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
